// File: include/vrc6_cfg.svh
// VRC6 mapper constants
`ifndef VRC6_CFG_SVH
`define VRC6_CFG_SVH

`define VRC6_CPU_AW         16
`define VRC6_PPU_AW         14
`define VRC6_PRG_OUT_W      22
`define VRC6_CHR_OUT_W      22

`define VRC6_PRG_BANK_W     6 // 8 KB banks
`define VRC6_CHR_BANK_W     8 // 1 KB banks

`define VRC6_WRAM_BASE      9'h1E0 // Upper address bits of work RAM
`define VRC6_CHR_BASE       3'b100 // CHR ROM region tag

// Scanline prescaler reloads
`define VRC6_SCALER_LONG    7'd113
`define VRC6_SCALER_SHORT   7'd112

`define VRC6_AUDIO_W        16

`endif

// File: run_sim.sh
#!/bin/sh
# Build and run the VRC6 mapper testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timescale 1ns/1ps -f vrc6_mapper.f \
	--top-module vrc6_mapper_tb -o vrc6_sim || { echo "build failed"; exit 1; }
./obj_dir/vrc6_sim 2>&1 | tee sim.log
grep -q '\*\*\* PASSED \*\*\*' sim.log && echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// File: tests/vrc6_mapper_tb.sv
// VRC6 mapper testbench
`timescale 1ns/1ps
`include "vrc6_cfg.svh"

module vrc6_mapper_tb;

	localparam int STIM_WORDS = 512; // Four words per record

	logic clk;
	logic reset;
	logic ce;
	logic swap_a0_a1;
	vrc6_pkg::cpu_bus_t bus;
	logic [`VRC6_PPU_AW-1:0] chr_addr;
	logic [`VRC6_AUDIO_W-1:0] audio_in;
	logic [`VRC6_PRG_OUT_W-1:0] prg_aout;
	logic prg_allow;
	logic [`VRC6_CHR_OUT_W-1:0] chr_aout;
	logic vram_ce;
	logic vram_a10;
	logic irq;
	logic [`VRC6_AUDIO_W-1:0] audio;

	logic [31:0] stim [0:STIM_WORDS-1];
	string test_name;
	int checks;
	int errors;
	int test_checks;
	int test_errors;

	vrc6_mapper DUT (.*);

	always #20 clk = ~clk;

	task automatic check_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		test_checks++;
		if (actual !== expected) begin
			errors++;
			test_errors++;
			$display("error %s %s: expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	task automatic note_failure(input string msg);
		errors++;
		test_errors++;
		$display("%s: %s", test_name, msg);
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data, input logic swap);
		@(posedge clk);
		bus.addr <= addr;
		bus.data <= data;
		bus.write <= 1'b1;
		swap_a0_a1 <= swap;
		@(negedge clk);
		// Only work RAM at 6000-7FFF takes CPU writes
		check_value("prg_allow", 32'(addr >= 16'h6000 && addr < 16'h8000), 32'(prg_allow));
		@(posedge clk); // Write edge
		bus.write <= 1'b0;
	endtask

	task automatic probe_prg(input logic [15:0] addr, input logic [31:0] expected);
		@(posedge clk);
		bus.addr <= addr;
		@(negedge clk);
		check_value("prg_aout", expected, 32'(prg_aout));
		check_value("prg_allow", 32'(addr >= 16'h6000), 32'(prg_allow)); // RAM or ROM read
	endtask

	task automatic probe_chr(input logic [13:0] addr, input logic [31:0] exp_aout,
		input logic [31:0] exp_a10);
		@(posedge clk);
		chr_addr <= addr;
		@(negedge clk);
		check_value("chr_aout", exp_aout, 32'(chr_aout));
		check_value("vram_ce", 32'(addr >= 14'h2000), 32'(vram_ce)); // Nametables from 2000
		check_value("vram_a10", exp_a10, 32'(vram_a10));
	endtask

	task automatic probe_audio(input logic [15:0] level_in, input logic [31:0] expected);
		@(posedge clk);
		audio_in <= level_in;
		@(negedge clk);
		check_value("audio", expected, 32'(audio));
	endtask

	task automatic check_irq(input logic [31:0] expected);
		@(negedge clk);
		check_value("irq", expected, 32'(irq));
	endtask

	// Counts edges after the control write until irq is seen high
	task automatic wait_irq(input int min_cycles, input int max_cycles);
		int cycles;
		cycles = 0;
		do begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
		end while (irq !== 1'b1 && cycles < max_cycles);
		if (irq !== 1'b1)
			note_failure($sformatf("irq did not rise within %0d cycles", max_cycles));
		else if (min_cycles == max_cycles)
			check_value("irq cycles", min_cycles, cycles);
		else if (cycles < min_cycles)
			note_failure($sformatf("irq rose after %0d cycles, before %0d", cycles, min_cycles));
	endtask

	function automatic string name_of(input logic [31:0] id);
		case (id)
			1: return "prg_banking";
			2: return "chr_banking";
			3: return "mirroring";
			4: return "irq_cycle_mode";
			5: return "irq_scanline_mode";
			6: return "audio_mix";
			default: return "unknown";
		endcase
	endfunction

	task automatic close_test();
		if (test_name != "")
			$display("%s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	initial begin
		int idx;
		logic done;
		logic [31:0] cmd;
		logic [31:0] a1;
		logic [31:0] a2;
		logic [31:0] a3;
		clk = 1'b0;
		reset <= 1'b1;
		ce <= 1'b1; // Every cycle is an M2 cycle
		swap_a0_a1 <= 1'b0;
		bus <= '0;
		chr_addr <= '0;
		audio_in <= '0;
		checks = 0;
		errors = 0;
		test_checks = 0;
		test_errors = 0;
		test_name = "";
		done = 1'b0;
		$readmemh("tests/vrc6_stim.txt", stim);
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		for (idx = 0; idx + 3 < STIM_WORDS && !done; idx += 4) begin
			cmd = stim[idx];
			a1 = stim[idx + 1];
			a2 = stim[idx + 2];
			a3 = stim[idx + 3];
			case (cmd)
				0: done = 1'b1;
				1: cpu_write(a1[15:0], a2[7:0], a3[0]);
				2: probe_prg(a1[15:0], a2);
				3: probe_chr(a1[13:0], a2, a3);
				4: wait_irq(a1, a2);
				5: probe_audio(a1[15:0], a2);
				6: check_irq(a1);
				7: begin
					close_test();
					test_name = name_of(a1);
				end
				default: note_failure($sformatf("unknown stimulus command %h", cmd));
			endcase
		end
		close_test();
		if (checks == 0) begin
			errors++;
			$display("no checks were run from the stimulus file");
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: tests/vrc6_stim.txt
// cmd a1 a2 a3: 1 write addr data swap, 2 prg addr aout, 3 chr addr aout a10,
// 4 irq wait min max, 5 audio in out, 6 irq level, 7 start test id, 0 end
7 1 0 0
1 8000 05 0
1 C000 2A 0
2 8123 014123 0
2 A456 016456 0
2 C789 054789 0
2 E001 07E001 0
2 6ABC 3C0ABC 0
1 8000 11 1
1 C000 07 1
2 8000 044000 0
2 D000 00F000 0
7 2 0 0
1 D000 10 0
1 D001 21 0
1 D002 32 0
1 D003 43 0
1 E000 54 0
1 E001 65 0
1 E002 76 0
1 E003 87 0
3 0000 204000 0
3 0C05 210C05 1
3 1FFF 221FFF 1
1 D001 99 1
3 0800 226400 0
3 0400 208400 1
7 3 0 0
1 B003 00 0
3 2400 208400 1
1 B003 04 0
3 2400 208400 0
1 B003 08 0
3 2C00 210C00 0
1 B003 0C 0
3 2000 204000 1
7 4 0 0
1 F000 F0 0
1 F001 07 0
4 10 10 0
1 F002 00 0
6 0 0 0
1 F001 00 0
7 5 0 0
1 F000 FE 0
1 F001 02 0
4 71 F0 0
1 F001 00 0
7 6 0 0
5 1234 091A 0
1 9000 85 0
1 9002 80 0
1 A000 87 0
1 A002 80 0
5 0000 0AAA 0
5 1000 12AA 0
5 4321 2C3A 0
5 FFFF 8AA9 0
0 0 0 0

// File: verilog/vrc6_addr_map.sv
// VRC6 PRG, CHR and nametable mapping
`timescale 1ns/1ps
`include "vrc6_cfg.svh"

module vrc6_addr_map (
	input  logic [`VRC6_CPU_AW-1:0]    prg_addr,
	input  logic [`VRC6_PPU_AW-1:0]    chr_addr,
	input  logic                       write,
	input  vrc6_pkg::bank_state_t      banks,
	output logic [`VRC6_PRG_OUT_W-1:0] prg_aout,
	output logic                       prg_allow,
	output logic [`VRC6_CHR_OUT_W-1:0] chr_aout,
	output logic                       vram_ce,
	output logic                       vram_a10
);

	localparam int PRG_PAD = `VRC6_PRG_OUT_W - `VRC6_PRG_BANK_W - 13;
	localparam int CHR_PAD = `VRC6_CHR_OUT_W - $bits(`VRC6_CHR_BASE) - `VRC6_CHR_BANK_W - 10;

	logic [`VRC6_PRG_BANK_W-1:0] prg_bank;
	logic [`VRC6_CHR_BANK_W-1:0] chr_bank;
	logic                        is_ram;

	assign is_ram = prg_addr[15:13] == 3'b011; // 6000-7FFF

	always_comb begin
		case (prg_addr[15:13])
			3'b100, 3'b101: prg_bank = {banks.prg_8000, prg_addr[13]}; // 8000-BFFF
			3'b110:         prg_bank = banks.prg_c000;
			3'b111:         prg_bank = '1; // Fixed last bank
			default:        prg_bank = '0;
		endcase
	end

	assign prg_aout = is_ram ? {`VRC6_WRAM_BASE, prg_addr[12:0]}
		: {{PRG_PAD{1'b0}}, prg_bank, prg_addr[12:0]};
	assign prg_allow = (prg_addr[15] && !write) || is_ram;

	assign chr_bank = banks.chr[chr_addr[12:10]];
	assign chr_aout = {`VRC6_CHR_BASE, {CHR_PAD{1'b0}}, chr_bank, chr_addr[9:0]};
	assign vram_ce = chr_addr[13];

	always_comb begin
		case (banks.mirror)
			vrc6_pkg::vertical:   vram_a10 = chr_addr[10];
			vrc6_pkg::horizontal: vram_a10 = chr_addr[11];
			vrc6_pkg::single_a:   vram_a10 = 1'b0;
			default:              vram_a10 = 1'b1;
		endcase
	end

endmodule

// File: verilog/vrc6_bank_regs.sv
// VRC6 bank and mirroring registers
`timescale 1ns/1ps
`include "vrc6_cfg.svh"

module vrc6_bank_regs (
	input  logic                  clk,
	input  logic                  reset,
	input  vrc6_pkg::reg_write_t  wr_evt,
	output vrc6_pkg::bank_state_t banks
);

	logic is_chr;
	logic [2:0] chr_idx;

	// CHR selects are contiguous in the enum
	assign is_chr = wr_evt.sel inside {[vrc6_pkg::chr_0:vrc6_pkg::chr_7]};
	assign chr_idx = 3'(wr_evt.sel - vrc6_pkg::chr_0);

	always_ff @(posedge clk) begin
		if (reset) begin
			banks.prg_8000 <= '0;
			banks.prg_c000 <= '0;
			banks.chr      <= '0;
			banks.mirror   <= vrc6_pkg::vertical;
		end else begin
			case (wr_evt.sel)
				vrc6_pkg::prg_8000:
					banks.prg_8000 <= wr_evt.data[`VRC6_PRG_BANK_W-2:0];
				vrc6_pkg::prg_c000:
					banks.prg_c000 <= wr_evt.data[`VRC6_PRG_BANK_W-1:0];
				vrc6_pkg::mirror:
					banks.mirror <= vrc6_pkg::mirror_e'(wr_evt.data[3:2]); // B003 bits 3:2
				default: begin
					if (is_chr)
						banks.chr[chr_idx] <= wr_evt.data[`VRC6_CHR_BANK_W-1:0];
				end
			endcase
		end
	end

endmodule

// File: verilog/vrc6_irq.sv
// VRC6 IRQ counter
`timescale 1ns/1ps
`include "vrc6_cfg.svh"

module vrc6_irq (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 ce,
	input  vrc6_pkg::reg_write_t wr_evt,
	output logic                 irq
);

	logic [7:0] latch;
	logic [7:0] count;
	logic [6:0] scaler;
	logic [1:0] line; // Position in the 3-line prescaler pattern
	logic       mode; // 1 = CPU cycle mode
	logic       enable;
	logic       ack_en;
	logic       tick;
	logic       reload;
	logic       clear;

	assign tick = mode || (scaler == '0);
	assign reload = (wr_evt.sel == vrc6_pkg::irq_ctrl) && wr_evt.data[1];
	assign clear = (wr_evt.sel == vrc6_pkg::irq_ctrl) || (wr_evt.sel == vrc6_pkg::irq_ack);

	always_ff @(posedge clk) begin
		if (reset) begin
			latch  <= '0;
			mode   <= 1'b0;
			enable <= 1'b0;
			ack_en <= 1'b0;
		end else begin
			case (wr_evt.sel)
				vrc6_pkg::irq_latch: latch <= wr_evt.data;
				vrc6_pkg::irq_ctrl:  {mode, enable, ack_en} <= wr_evt.data[2:0];
				vrc6_pkg::irq_ack:   enable <= ack_en;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			count  <= '0;
			scaler <= '0;
			line   <= '0;
		end else if (reload) begin
			count  <= latch;
			scaler <= `VRC6_SCALER_LONG;
			line   <= '0;
		end else if (ce && enable) begin
			if (scaler != '0) begin
				scaler <= scaler - 7'd1;
			end else begin
				scaler <= line[1] ? `VRC6_SCALER_SHORT : `VRC6_SCALER_LONG;
				line   <= line[1] ? 2'd0 : line + 2'd1;
			end
			if (tick)
				count <= (count == 8'hFF) ? latch : count + 8'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			irq <= 1'b0;
		else if (clear)
			irq <= 1'b0; // Control or ack write drops the request
		else if (ce && enable && tick && count == 8'hFF)
			irq <= 1'b1;
	end

	// A request never appears together with a disabled counter
	assert property (@(posedge clk) disable iff (reset) !enable |-> !$rose(irq));

endmodule

// File: verilog/vrc6_mapper.sv
// VRC6 mapper top level
`timescale 1ns/1ps
`include "vrc6_cfg.svh"

module vrc6_mapper (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       ce,         // M2 enable
	input  logic                       swap_a0_a1, // Set for mapper 26
	input  vrc6_pkg::cpu_bus_t         bus,
	input  logic [`VRC6_PPU_AW-1:0]    chr_addr,
	input  logic [`VRC6_AUDIO_W-1:0]   audio_in,   // APU audio level
	output logic [`VRC6_PRG_OUT_W-1:0] prg_aout,
	output logic                       prg_allow,
	output logic [`VRC6_CHR_OUT_W-1:0] chr_aout,
	output logic                       vram_ce,
	output logic                       vram_a10,
	output logic                       irq,
	output logic [`VRC6_AUDIO_W-1:0]   audio
);

	vrc6_pkg::reg_write_t  wr_evt;
	vrc6_pkg::bank_state_t banks;
	logic [3:0] p1_level;
	logic [3:0] p2_level;
	logic [4:0] saw_level;
	logic [5:0] exp_sum;
	logic [`VRC6_AUDIO_W-1:0] exp_audio;
	logic [`VRC6_AUDIO_W:0]   mixed;

	vrc6_reg_decode u_decode (.clk, .reset, .ce, .swap_a0_a1, .bus, .wr_evt);

	vrc6_bank_regs u_banks (.clk, .reset, .wr_evt, .banks);

	vrc6_addr_map u_map (
		.prg_addr  (bus.addr),
		.chr_addr  (chr_addr),
		.write     (bus.write),
		.banks     (banks),
		.prg_aout  (prg_aout),
		.prg_allow (prg_allow),
		.chr_aout  (chr_aout),
		.vram_ce   (vram_ce),
		.vram_a10  (vram_a10)
	);

	vrc6_irq u_irq (.clk, .reset, .ce, .wr_evt, .irq);

	vrc6_pulse u_pulse1 (.clk, .reset, .ce, .wr_evt, .is_second(1'b0), .level(p1_level));
	vrc6_pulse u_pulse2 (.clk, .reset, .ce, .wr_evt, .is_second(1'b1), .level(p2_level));
	vrc6_saw u_saw (.clk, .reset, .ce, .wr_evt, .level(saw_level));

	// Channels sum before the amp, then stretch to full scale
	assign exp_sum = {2'b00, p1_level} + {2'b00, p2_level} + {1'b0, saw_level};
	assign exp_audio = {exp_sum, exp_sum, exp_sum[5:2]};

	// About 0.44 of the raw level to sit near APU loudness
	assign mixed = {1'b0, audio_in} + {1'b0, exp_audio >> 2} + {1'b0, exp_audio >> 3}
		+ {1'b0, exp_audio >> 4};
	assign audio = mixed[`VRC6_AUDIO_W:1];

endmodule

// File: verilog/vrc6_pkg.sv
// VRC6 mapper types
`include "vrc6_cfg.svh"

package vrc6_pkg;

	// Register targets of a CPU write
	typedef enum logic [4:0] {
		prg_8000,
		prg_c000,
		mirror,
		chr_0, chr_1, chr_2, chr_3,
		chr_4, chr_5, chr_6, chr_7,
		irq_latch, irq_ctrl, irq_ack,
		pulse1_ctrl, pulse1_lo, pulse1_hi,
		pulse2_ctrl, pulse2_lo, pulse2_hi,
		saw_rate, saw_lo, saw_hi,
		none
	} reg_sel_e;

	typedef enum logic [1:0] {
		vertical,
		horizontal,
		single_a,
		single_b
	} mirror_e;

	typedef struct packed {
		logic [`VRC6_CPU_AW-1:0] addr;
		logic [7:0]              data;
		logic                    write;
	} cpu_bus_t;

	typedef struct packed {
		reg_sel_e   sel; // none when no write this cycle
		logic [7:0] data;
	} reg_write_t;

	typedef struct packed {
		logic [`VRC6_PRG_BANK_W-2:0]          prg_8000; // 16 KB window with A13 appended
		logic [`VRC6_PRG_BANK_W-1:0]          prg_c000;
		logic [7:0][`VRC6_CHR_BANK_W-1:0]     chr;
		mirror_e                              mirror;
	} bank_state_t;

endpackage

// File: verilog/vrc6_pulse.sv
// VRC6 pulse channel
`timescale 1ns/1ps
`include "vrc6_cfg.svh"

module vrc6_pulse (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 ce,
	input  vrc6_pkg::reg_write_t wr_evt,
	input  logic                 is_second, // Selects the A00x register set
	output logic [3:0]           level
);

	vrc6_pkg::reg_sel_e ctrl_sel, lo_sel, hi_sel;
	logic [3:0]  vol;
	logic [2:0]  duty;
	logic [11:0] period;
	logic        mode; // Constant volume output
	logic        en;
	logic [11:0] div;
	logic [3:0]  step;
	logic [4:0]  duty_pos;

	assign ctrl_sel = is_second ? vrc6_pkg::pulse2_ctrl : vrc6_pkg::pulse1_ctrl;
	assign lo_sel = is_second ? vrc6_pkg::pulse2_lo : vrc6_pkg::pulse1_lo;
	assign hi_sel = is_second ? vrc6_pkg::pulse2_hi : vrc6_pkg::pulse1_hi;

	always_ff @(posedge clk) begin
		if (wr_evt.sel == ctrl_sel)
			{duty, vol} <= wr_evt.data[6:0];
		if (wr_evt.sel == lo_sel)
			period[7:0] <= wr_evt.data;
		if (wr_evt.sel == hi_sel)
			period[11:8] <= wr_evt.data[3:0];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mode <= 1'b0;
			en   <= 1'b0;
			div  <= '0;
			step <= '0;
		end else begin
			if (wr_evt.sel == ctrl_sel)
				mode <= wr_evt.data[7];
			if (wr_evt.sel == hi_sel)
				en <= wr_evt.data[7];
			if (ce && en) begin
				if (div != '0) begin
					div <= div - 12'd1;
				end else begin
					div  <= period;
					step <= step + 4'd1;
				end
			end
		end
	end

	// Carry out means the step is past the duty point
	assign duty_pos = {1'b0, step} + {2'b01, ~duty};
	assign level = ((!duty_pos[4] || mode) && en) ? vol : 4'd0;

endmodule

// File: verilog/vrc6_reg_decode.sv
// VRC6 CPU register decoder
`timescale 1ns/1ps
`include "vrc6_cfg.svh"

module vrc6_reg_decode (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  ce,
	input  logic                  swap_a0_a1, // Mapper 26 wiring
	input  vrc6_pkg::cpu_bus_t    bus,
	output vrc6_pkg::reg_write_t  wr_evt
);

	logic [`VRC6_CPU_AW-1:0] ain;
	vrc6_pkg::reg_sel_e      sel;

	assign ain = swap_a0_a1 ? {bus.addr[`VRC6_CPU_AW-1:2], bus.addr[0], bus.addr[1]} : bus.addr;

	always_comb begin
		casez ({ain[`VRC6_CPU_AW-1:`VRC6_CPU_AW-4], ain[1:0]})
			6'b1000_??: sel = vrc6_pkg::prg_8000;
			6'b1001_00: sel = vrc6_pkg::pulse1_ctrl;
			6'b1001_01: sel = vrc6_pkg::pulse1_lo;
			6'b1001_10: sel = vrc6_pkg::pulse1_hi;
			6'b1010_00: sel = vrc6_pkg::pulse2_ctrl;
			6'b1010_01: sel = vrc6_pkg::pulse2_lo;
			6'b1010_10: sel = vrc6_pkg::pulse2_hi;
			6'b1011_00: sel = vrc6_pkg::saw_rate;
			6'b1011_01: sel = vrc6_pkg::saw_lo;
			6'b1011_10: sel = vrc6_pkg::saw_hi;
			6'b1011_11: sel = vrc6_pkg::mirror;
			6'b1100_??: sel = vrc6_pkg::prg_c000;
			6'b1101_00: sel = vrc6_pkg::chr_0;
			6'b1101_01: sel = vrc6_pkg::chr_1;
			6'b1101_10: sel = vrc6_pkg::chr_2;
			6'b1101_11: sel = vrc6_pkg::chr_3;
			6'b1110_00: sel = vrc6_pkg::chr_4;
			6'b1110_01: sel = vrc6_pkg::chr_5;
			6'b1110_10: sel = vrc6_pkg::chr_6;
			6'b1110_11: sel = vrc6_pkg::chr_7;
			6'b1111_00: sel = vrc6_pkg::irq_latch;
			6'b1111_01: sel = vrc6_pkg::irq_ctrl;
			6'b1111_10: sel = vrc6_pkg::irq_ack;
			default:    sel = vrc6_pkg::none;
		endcase
		if (!(ce && bus.write))
			sel = vrc6_pkg::none; // Only on an M2-qualified write
	end

	assign wr_evt = {sel, bus.data};

	// CPU must stay off the bus while the mapper is held in reset
	assert property (@(posedge clk) reset |-> wr_evt.sel == vrc6_pkg::none);

endmodule

// File: verilog/vrc6_saw.sv
// VRC6 sawtooth channel
`timescale 1ns/1ps
`include "vrc6_cfg.svh"

module vrc6_saw (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 ce,
	input  vrc6_pkg::reg_write_t wr_evt,
	output logic [4:0]           level
);

	logic [5:0]  rate;
	logic [11:0] period;
	logic        en;
	logic [12:0] div;
	logic [2:0]  step;
	logic [7:0]  acc;

	always_ff @(posedge clk) begin
		if (wr_evt.sel == vrc6_pkg::saw_rate)
			rate <= wr_evt.data[5:0];
		if (wr_evt.sel == vrc6_pkg::saw_lo)
			period[7:0] <= wr_evt.data;
		if (wr_evt.sel == vrc6_pkg::saw_hi)
			period[11:8] <= wr_evt.data[3:0];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			en   <= 1'b0;
			div  <= '0;
			step <= '0;
			acc  <= '0;
		end else begin
			if (wr_evt.sel == vrc6_pkg::saw_hi)
				en <= wr_evt.data[7];
			if (ce && en) begin
				if (div != '0) begin
					div <= div - 13'd1;
				end else begin
					div <= {period, 1'b1}; // Accumulator clocks at half rate
					if (step == 3'd6) begin
						step <= '0;
						acc  <= '0;
					end else begin
						step <= step + 3'd1;
						acc  <= acc + {2'b00, rate};
					end
				end
			end
		end
	end

	assign level = en ? acc[7:3] : 5'd0;

endmodule

// File: vrc6_mapper.f
+incdir+include
verilog/vrc6_pkg.sv
verilog/vrc6_reg_decode.sv
verilog/vrc6_bank_regs.sv
verilog/vrc6_addr_map.sv
verilog/vrc6_irq.sv
verilog/vrc6_pulse.sv
verilog/vrc6_saw.sv
verilog/vrc6_mapper.sv
tests/vrc6_mapper_tb.sv
